// File: hw/aluPkg.sv
// shared widths, encodings and bundles for the pipelined ALU
package aluPkg;

    // operand and result width
    localparam int dataWidth = 8;

    // shift amount field in DATA2
    // top bit set means an amount of 8 or more
    localparam int shiftAmtWidth = 4;

    // opcodes as seen in the request op field
    typedef enum logic [2:0] {
        opForward     = 3'd0,
        opAdd         = 3'd1,
        opAnd         = 3'd2,
        opOr          = 3'd3,
        opMult        = 3'd4,
        opShiftLeft   = 3'd5,
        opShiftRight  = 3'd6,
        opRotateRight = 3'd7
    } aluOp_e;

    // right shift mode from DATA2[7:6]
    // reserved code behaves as logical
    typedef enum logic [1:0] {
        modeLogical  = 2'd0,
        modeArith    = 2'd1,
        modeRotate   = 2'd2,
        modeReserved = 2'd3
    } shiftMode_e;

    // one operation as presented at the input strobe
    typedef struct packed {
        aluOp_e               op;
        logic [dataWidth-1:0] data1;
        logic [dataWidth-1:0] data2;
    } aluRequest_t;

    // registered answer
    typedef struct packed {
        logic [dataWidth-1:0] result;
        logic                 zero;
    } aluResult_t;

endpackage

// File: hw/operandStage.sv
`timescale 1ns/10ps

// first pipeline register, operands in
module operandStage (
    input  logic                CLK,
    input  logic                rstN,
    input  logic                inValid,
    input  aluPkg::aluRequest_t request,
    output aluPkg::aluRequest_t heldRequest,
    output logic                heldValid
);

    // valid bit follows the input strobe every cycle
    // a low strobe becomes a bubble in stage two
    always_ff @(posedge CLK or negedge rstN)
    begin
        if (!rstN)
            heldValid <= 1'b0;
        else
            heldValid <= inValid;
    end

    // operands only captured on a strobe
    // held through bubbles
    always_ff @(posedge CLK)
    begin
        if (inValid)
            heldRequest <= request;
    end

endmodule

// File: hw/arithLogicUnit.sv
`timescale 1ns/10ps

// forward, add, and, or plus the zero flag
module arithLogicUnit (
    input  logic [aluPkg::dataWidth-1:0] data1,
    input  logic [aluPkg::dataWidth-1:0] data2,
    output logic [aluPkg::dataWidth-1:0] forwardValue,
    output logic [aluPkg::dataWidth-1:0] sum,
    output logic [aluPkg::dataWidth-1:0] andValue,
    output logic [aluPkg::dataWidth-1:0] orValue,
    output logic                         sumZero
);

    // forward passes the second operand
    assign forwardValue = data2;

    // carry out dropped so the add wraps modulo 256
    assign sum = data1 + data2;

    // bitwise ops
    assign andValue = data1 & data2;
    assign orValue  = data1 | data2;

    // zero flag always from the adder
    // independent of the selected op
    // branch logic relies on this
    assign sumZero = (sum == '0);

endmodule

// File: hw/arrayMultiplier.sv
`timescale 1ns/10ps

// shift-and-add array multiplier
// low half of the product only
module arrayMultiplier (
    input  logic [aluPkg::dataWidth-1:0] multiplicand,
    input  logic [aluPkg::dataWidth-1:0] multiplier,
    output logic [aluPkg::dataWidth-1:0] product
);

    // running sum after each row
    // entry 0 is the empty sum, last entry the product
    logic [aluPkg::dataWidth-1:0] rowSum [0:aluPkg::dataWidth];

    assign rowSum[0] = '0;

    // one row per multiplier bit
    for (genvar row = 0; row < aluPkg::dataWidth; row++)
    begin : gRow
        // gated multiplicand for this bit
        logic [aluPkg::dataWidth-1:0] gated;
        // gated value moved to its weight
        logic [aluPkg::dataWidth-1:0] partial;

        assign gated = multiplicand & {aluPkg::dataWidth{multiplier[row]}};

        // bits pushed past the top are lost here
        assign partial = gated << row;

        // row adder drops the carry out of bit 7
        assign rowSum[row+1] = rowSum[row] + partial;
    end

    // low eight bits of data1 * data2
    assign product = rowSum[aluPkg::dataWidth];

endmodule

// File: hw/barrelShifter.sv
`timescale 1ns/10ps

// log barrel shifter for left shift, right shift and rotate
module barrelShifter (
    input  logic [aluPkg::dataWidth-1:0] data1,
    input  logic [aluPkg::dataWidth-1:0] shiftCtrl,
    input  aluPkg::aluOp_e               op,
    output logic [aluPkg::dataWidth-1:0] shifted
);

    logic [aluPkg::shiftAmtWidth-1:0] amount;
    // amount of 8 or more
    logic                             bigAmount;
    aluPkg::shiftMode_e               requestedMode;
    // mode after op overrides
    aluPkg::shiftMode_e               fillMode;
    logic                             shiftLeft;
    logic                             signBit;

    // per level outputs
    // entry 0 is the operand
    logic [aluPkg::dataWidth-1:0] stage [0:aluPkg::shiftAmtWidth-1];

    assign amount        = shiftCtrl[aluPkg::shiftAmtWidth-1:0];
    assign bigAmount     = amount[aluPkg::shiftAmtWidth-1];
    assign requestedMode = aluPkg::shiftMode_e'(shiftCtrl[aluPkg::dataWidth-1 -: 2]);
    assign shiftLeft     = (op == aluPkg::opShiftLeft);
    assign signBit       = data1[aluPkg::dataWidth-1];

    // rotate op ignores the mode field
    // left shift always zero fills
    always_comb
    begin
        if (op == aluPkg::opRotateRight)
            fillMode = aluPkg::modeRotate;
        else if (shiftLeft)
            fillMode = aluPkg::modeLogical;
        else
            fillMode = requestedMode;
    end

    assign stage[0] = data1;

    // three levels cover amounts 0..7
    for (genvar k = 0; k < aluPkg::shiftAmtWidth-1; k++)
    begin : gLevel
        // bits entering from the top on a right move
        logic [(1<<k)-1:0]            fillBits;
        logic [aluPkg::dataWidth-1:0] leftValue;
        logic [aluPkg::dataWidth-1:0] rightValue;

        always_comb
        begin
            case (fillMode)
                // wrapped low bits come back on top
                aluPkg::modeRotate: fillBits = stage[k][(1<<k)-1:0];
                // sign copies
                // msb unchanged through every level
                aluPkg::modeArith:  fillBits = {(1<<k){stage[k][aluPkg::dataWidth-1]}};
                // logical and reserved
                default:            fillBits = '0;
            endcase
        end

        assign leftValue  = {stage[k][aluPkg::dataWidth-1-(1<<k):0], {(1<<k){1'b0}}};
        assign rightValue = {fillBits, stage[k][aluPkg::dataWidth-1:(1<<k)]};

        // amount bit k moves by 2^k
        assign stage[k+1] = amount[k] ? (shiftLeft ? leftValue : rightValue) : stage[k];
    end

    // amounts of 8 or more
    // rotate just wraps on the low three bits
    always_comb
    begin
        if (!bigAmount || fillMode == aluPkg::modeRotate)
            shifted = stage[aluPkg::shiftAmtWidth-1];
        else if (fillMode == aluPkg::modeArith)
            shifted = {aluPkg::dataWidth{signBit}};
        else
            shifted = '0;
    end

endmodule

// File: hw/resultStage.sv
`timescale 1ns/10ps

// result select and second pipeline register
module resultStage (
    input  logic                         CLK,
    input  logic                         rstN,
    input  logic                         heldValid,
    input  aluPkg::aluOp_e               op,
    input  logic [aluPkg::dataWidth-1:0] forwardValue,
    input  logic [aluPkg::dataWidth-1:0] sum,
    input  logic [aluPkg::dataWidth-1:0] andValue,
    input  logic [aluPkg::dataWidth-1:0] orValue,
    input  logic [aluPkg::dataWidth-1:0] product,
    input  logic [aluPkg::dataWidth-1:0] shifted,
    input  logic                         sumZero,
    output aluPkg::aluResult_t           response,
    output logic                         outValid
);

    // selected unit output for the held op
    logic [aluPkg::dataWidth-1:0] selected;

    // every opcode decoded
    always_comb
    begin
        unique case (op)
            aluPkg::opForward:     selected = forwardValue;
            aluPkg::opAdd:         selected = sum;
            aluPkg::opAnd:         selected = andValue;
            aluPkg::opOr:          selected = orValue;
            aluPkg::opMult:        selected = product;
            // all three shift ops share one shifter
            aluPkg::opShiftLeft,
            aluPkg::opShiftRight,
            aluPkg::opRotateRight: selected = shifted;
        endcase
    end

    // one pulse per request
    // two cycles after inValid
    always_ff @(posedge CLK or negedge rstN)
    begin
        if (!rstN)
            outValid <= 1'b0;
        else
            outValid <= heldValid;
    end

    // response zero out of reset
    // keeps its last value during bubbles
    always_ff @(posedge CLK or negedge rstN)
    begin
        if (!rstN)
        begin
            response <= '0;
        end
        else if (heldValid)
        begin
            response.result <= selected;
            response.zero   <= sumZero;
        end
    end

endmodule

// File: hw/aluPipe.sv
`timescale 1ns/10ps

// two stage pipelined 8-bit ALU
module aluPipe (
    input  logic                CLK,
    input  logic                rstN,
    input  logic                inValid,
    input  aluPkg::aluRequest_t request,
    output logic                outValid,
    output aluPkg::aluResult_t  response
);

    // stage one outputs
    aluPkg::aluRequest_t heldRequest;
    logic                heldValid;

    // unit results
    logic [aluPkg::dataWidth-1:0] forwardValue;
    logic [aluPkg::dataWidth-1:0] sum;
    logic [aluPkg::dataWidth-1:0] andValue;
    logic [aluPkg::dataWidth-1:0] orValue;
    logic [aluPkg::dataWidth-1:0] product;
    logic [aluPkg::dataWidth-1:0] shifted;
    logic                         sumZero;

    operandStage operandStage_inst (
        .CLK         (CLK),
        .rstN        (rstN),
        .inValid     (inValid),
        .request     (request),
        .heldRequest (heldRequest),
        .heldValid   (heldValid)
    );

    // units all combinational, work off the held operands
    arithLogicUnit arithLogicUnit_inst (
        .data1        (heldRequest.data1),
        .data2        (heldRequest.data2),
        .forwardValue (forwardValue),
        .sum          (sum),
        .andValue     (andValue),
        .orValue      (orValue),
        .sumZero      (sumZero)
    );

    arrayMultiplier arrayMultiplier_inst (
        .multiplicand (heldRequest.data1),
        .multiplier   (heldRequest.data2),
        .product      (product)
    );

    // DATA2 carries both amount and mode
    barrelShifter barrelShifter_inst (
        .data1     (heldRequest.data1),
        .shiftCtrl (heldRequest.data2),
        .op        (heldRequest.op),
        .shifted   (shifted)
    );

    resultStage resultStage_inst (
        .CLK          (CLK),
        .rstN         (rstN),
        .heldValid    (heldValid),
        .op           (heldRequest.op),
        .forwardValue (forwardValue),
        .sum          (sum),
        .andValue     (andValue),
        .orValue      (orValue),
        .product      (product),
        .shifted      (shifted),
        .sumZero      (sumZero),
        .response     (response),
        .outValid     (outValid)
    );

endmodule

// File: verification/aluPipe_props.sv
`timescale 1ns/10ps

// strobe and reset properties, bound into aluPipe
module aluPipe_props (
    input logic               CLK,
    input logic               rstN,
    input logic               inValid,
    input logic               outValid,
    input aluPkg::aluResult_t response
);

    // fixed two cycle latency, one pulse per request
    assert property (@(posedge CLK) disable iff (!rstN)
        outValid == $past(inValid, 2))
    else
        $error("outValid does not follow inValid of two cycles earlier");

    // nothing leaves the pipe while in reset
    assert property (@(posedge CLK) !rstN |-> !outValid)
    else
        $error("outValid high during reset");

    // valid results are fully known
    assert property (@(posedge CLK) disable iff (!rstN)
        outValid |-> !$isunknown(response))
    else
        $error("response unknown while outValid is high");

endmodule

// File: verification/aluPipeTb.sv
`timescale 1ns/10ps

// directed testbench for the two stage ALU
module aluPipeTb;

    // one request waiting for its result
    typedef struct packed {
        aluPkg::aluRequest_t req;
        logic [31:0]         issueCycle;
    } pendingReq_t;

    logic                CLK = 1'b0;
    logic                rstN;
    logic                inValid;
    aluPkg::aluRequest_t request;
    logic                outValid;
    aluPkg::aluResult_t  response;

    pendingReq_t pending [$];
    logic [31:0] cycleCount = '0;
    int          errorCount = 0;
    int          testsRun = 0;
    int          testsFailed = 0;
    int          testStartErrors;

    aluPipe aluPipe_inst (
        .CLK      (CLK),
        .rstN     (rstN),
        .inValid  (inValid),
        .request  (request),
        .outValid (outValid),
        .response (response)
    );

    bind aluPipe aluPipe_props aluPipe_props_inst (
        .CLK      (CLK),
        .rstN     (rstN),
        .inValid  (inValid),
        .outValid (outValid),
        .response (response)
    );

    // 40 ns period
    always #20 CLK = ~CLK;

    always @(posedge CLK)
        cycleCount <= cycleCount + 1;

    // expected result straight from the opcode rules
    function automatic logic [7:0] modelResult(aluPkg::aluOp_e op, logic [7:0] a, logic [7:0] b);
        logic [3:0]  amt;
        logic [1:0]  mode;
        logic [15:0] fullProduct;
        logic [15:0] doubled;
        amt = b[3:0];
        // rotate op overrides the mode field
        mode = (op == aluPkg::opRotateRight) ? aluPkg::modeRotate : b[7:6];
        fullProduct = 16'(a) * 16'(b);
        // rotate keeps only the low three amount bits
        doubled = {a, a} >> amt[2:0];
        case (op)
            aluPkg::opForward:   return b;
            aluPkg::opAdd:       return 8'(a + b);
            aluPkg::opAnd:       return a & b;
            aluPkg::opOr:        return a | b;
            aluPkg::opMult:      return fullProduct[7:0];
            aluPkg::opShiftLeft: return (amt > 4'd7) ? 8'h00 : 8'(a << amt);
            default:
            begin
                if (mode == aluPkg::modeRotate)
                    return doubled[7:0];
                else if (mode == aluPkg::modeArith)
                    return (amt > 4'd7) ? {8{a[7]}} : 8'($signed(a) >>> amt);
                else
                    return (amt > 4'd7) ? 8'h00 : (a >> amt);
            end
        endcase
    endfunction

    // compares each outValid pulse with the oldest outstanding request
    always @(negedge CLK)
    begin
        pendingReq_t head;
        logic [7:0]  expResult;
        logic [7:0]  expSum;
        if (rstN && outValid)
        begin
            assert (pending.size() != 0)
            else
            begin
                $display("outValid pulse arrived with no request outstanding");
                errorCount++;
            end
            if (pending.size() != 0)
            begin
                head = pending.pop_front();
                expResult = modelResult(head.req.op, head.req.data1, head.req.data2);
                // zero flag from the sum whatever the op
                expSum = 8'(head.req.data1 + head.req.data2);
                assert (response.result == expResult)
                else
                begin
                    $display("Mismatch response.result: got 0x%02h expected 0x%02h op %0d",
                             response.result, expResult, head.req.op);
                    errorCount++;
                end
                assert (response.zero == (expSum == 8'h00))
                else
                begin
                    $display("Mismatch response.zero: got 0x%0h expected 0x%0h",
                             response.zero, (expSum == 8'h00));
                    errorCount++;
                end
                assert (cycleCount - head.issueCycle == 32'd2)
                else
                begin
                    $display("result came back after %0d cycles instead of two",
                             cycleCount - head.issueCycle);
                    errorCount++;
                end
            end
        end
    end

    // one request per falling edge
    // inValid stays high between calls
    task automatic sendReq(input aluPkg::aluOp_e op, input logic [7:0] a, input logic [7:0] b);
        pendingReq_t entry;
        @(negedge CLK);
        request = '{op: op, data1: a, data2: b};
        inValid = 1'b1;
        entry.req = request;
        entry.issueCycle = cycleCount;
        pending.push_back(entry);
    endtask

    // one empty cycle in the stream
    task automatic bubble();
        @(negedge CLK);
        inValid = 1'b0;
    endtask

    // stop issuing and wait for every outstanding result
    task automatic drainAll(input string testName);
        int waited;
        bubble();
        waited = 0;
        while (pending.size() != 0 && waited < 20)
        begin
            @(negedge CLK);
            waited++;
        end
        assert (pending.size() == 0)
        else
        begin
            $display("timeout in %s: %0d results never came back", testName, pending.size());
            errorCount++;
            pending.delete();
        end
    endtask

    task automatic finishTest(input string testName);
        testsRun++;
        if (errorCount == testStartErrors)
            $display("test %s: passed", testName);
        else
        begin
            testsFailed++;
            $display("test %s: failed with %0d errors", testName, errorCount - testStartErrors);
        end
    endtask

    // outputs idle until the first request
    task automatic checkResetIdle();
        testStartErrors = errorCount;
        repeat (3)
        begin
            @(negedge CLK);
            assert (outValid == 1'b0)
            else
            begin
                $display("Mismatch outValid: got 0x%0h expected 0x0", outValid);
                errorCount++;
            end
            assert (response == '0)
            else
            begin
                $display("Mismatch response: got 0x%03h expected 0x000", response);
                errorCount++;
            end
        end
        finishTest("reset");
    endtask

    task automatic exerciseSimpleOps();
        testStartErrors = errorCount;
        // sums that wrap to zero
        sendReq(aluPkg::opAdd, 8'h80, 8'h80);
        sendReq(aluPkg::opAdd, 8'h01, 8'hff);
        sendReq(aluPkg::opForward, 8'h3c, 8'hc4);
        sendReq(aluPkg::opAnd, 8'hf0, 8'h3c);
        sendReq(aluPkg::opOr, 8'h00, 8'h00);
        repeat (24)
            sendReq(aluPkg::aluOp_e'($urandom_range(3, 0)), 8'($urandom), 8'($urandom));
        drainAll("simpleOps");
        finishTest("simpleOps");
    endtask

    task automatic multiplyPairs();
        testStartErrors = errorCount;
        sendReq(aluPkg::opMult, 8'hff, 8'hff);
        sendReq(aluPkg::opMult, 8'h00, 8'ha5);
        sendReq(aluPkg::opMult, 8'h10, 8'h10);
        sendReq(aluPkg::opMult, 8'h80, 8'h03);
        repeat (24)
            sendReq(aluPkg::opMult, 8'($urandom), 8'($urandom));
        drainAll("multiply");
        finishTest("multiply");
    endtask

    task automatic sweepLeftShifts();
        testStartErrors = errorCount;
        for (int amt = 0; amt < 16; amt++)
            sendReq(aluPkg::opShiftLeft, 8'($urandom) | 8'h81, {4'($urandom), 4'(amt)});
        drainAll("shiftLeft");
        finishTest("shiftLeft");
    endtask

    // every mode and amount
    // sign bit set on odd amounts
    task automatic sweepRightShifts();
        logic [7:0] data;
        testStartErrors = errorCount;
        for (int mode = 0; mode < 4; mode++)
        begin
            for (int amt = 0; amt < 16; amt++)
            begin
                data = (amt % 2 == 1) ? (8'($urandom) | 8'h80) : (8'($urandom) & 8'h7f);
                sendReq(aluPkg::opShiftRight, data, {2'(mode), 2'($urandom), 4'(amt)});
                sendReq(aluPkg::opRotateRight, data, {2'(mode), 2'($urandom), 4'(amt)});
            end
        end
        drainAll("shiftRight");
        finishTest("shiftRight");
    endtask

    // random ops with random gaps between them
    task automatic streamWithBubbles();
        testStartErrors = errorCount;
        repeat (40)
        begin
            sendReq(aluPkg::aluOp_e'($urandom_range(7, 0)), 8'($urandom), 8'($urandom));
            if ($urandom_range(1, 0) == 1)
                bubble();
        end
        drainAll("pipelining");
        finishTest("pipelining");
    endtask

    initial
    begin
        void'($urandom(32'hecfe_0c50));
        rstN = 1'b0;
        inValid = 1'b0;
        request = '0;
        repeat (5) @(posedge CLK);
        @(negedge CLK);
        rstN = 1'b1;
        checkResetIdle();
        exerciseSimpleOps();
        multiplyPairs();
        sweepLeftShifts();
        sweepRightShifts();
        streamWithBubbles();
        $display("tests run %0d, tests failed %0d, errors %0d", testsRun, testsFailed, errorCount);
        if (errorCount == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

// File: aluPipe.f
hw/aluPkg.sv
hw/operandStage.sv
hw/arithLogicUnit.sv
hw/arrayMultiplier.sv
hw/barrelShifter.sv
hw/resultStage.sv
hw/aluPipe.sv
verification/aluPipe_props.sv
verification/aluPipeTb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the aluPipe testbench with Verilator.
# Returns a failing status when the log holds the fail message.
set -eo pipefail

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module aluPipeTb \
    -f aluPipe.f \
    -o aluPipeSim

./obj_dir/aluPipeSim | tee sim.log

if grep -q '\*\* FAIL \*\*' sim.log; then
    echo "simulation reported failure"
    exit 1
fi

echo "simulation finished without failure"
